// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = issue_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/issue_asserts.sv
`timescale 1ns/100ps

module issue_asserts import issue_pkg::*; (
	input logic                 clock,
	input logic                 rst_n,
	input logic                 issue_fire,
	input logic                 full,
	input logic [ROB_TAG_W-1:0] alloc_tag,
	input logic                 cdb_valid,
	input logic [ROB_TAG_W-1:0] cdb_tag,
	input logic                 commit_valid,
	input logic [ROB_TAG_W-1:0] commit_tag,
	input logic                 x0_busy
);

	logic completed [2**ROB_TAG_W];  // completion seen since allocation

	// allocation clears and a completion sets
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			completed <= '{default: 1'b0};
		end else begin
			if (issue_fire)
				completed[alloc_tag] <= 1'b0;
			if (cdb_valid)
				completed[cdb_tag] <= 1'b1;
		end
	end

	// a full rob takes nothing new
	no_alloc_when_full: assert property (@(posedge clock) disable iff (!rst_n)
		!(issue_fire && full))
		else $error("entry allocated while the reorder buffer is full");

	// the head must have seen its completion before it retires
	head_done_on_commit: assert property (@(posedge clock) disable iff (!rst_n)
		commit_valid |-> completed[commit_tag])
		else $error("commit of a head entry that has not completed");

	// x0 is never renamed
	x0_not_busy: assert property (@(posedge clock) disable iff (!rst_n)
		!x0_busy)
		else $error("map entry for x0 is marked busy");

endmodule

bind rob issue_asserts rob_checks (
	.clock        (clock),
	.rst_n        (rst_n),
	.issue_fire   (issue_fire),
	.full         (full),
	.alloc_tag    (alloc_tag),
	.cdb_valid    (cdb.valid),
	.cdb_tag      (cdb.rob_tag),
	.commit_valid (commit.valid),
	.commit_tag   (commit_tag),
	.x0_busy      (1'b0)
);

bind map_table issue_asserts map_checks (
	.clock        (clock),
	.rst_n        (rst_n),
	.issue_fire   (issue_fire),
	.full         (1'b0),
	.alloc_tag    (alloc_tag),
	.cdb_valid    (cdb.valid),
	.cdb_tag      (cdb.rob_tag),
	.commit_valid (commit_valid),
	.commit_tag   (commit_tag),
	.x0_busy      (entry[0].busy)
);

// File: bench/issue_tb.sv
`timescale 1ns/100ps

module issue_tb import issue_pkg::*; ();

	localparam int ROB_DEPTH  = 8;
	localparam int NUM_TESTS  = 2000;
	localparam int MAX_CYCLES = NUM_TESTS * 4;

	// funct3/funct7 picks per op, funct7 only matters for the shifts
	localparam logic [2:0] IMM_F3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
	localparam logic [6:0] IMM_F7 [9] = '{7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
		7'h00, 7'h00, 7'h20};
	localparam ALU_FUNC IMM_FN [9] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA};
	localparam logic [2:0] REG_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5,
		3'd6, 3'd7};
	localparam logic [6:0] REG_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
		7'h20, 7'h00, 7'h00};
	localparam ALU_FUNC REG_FN [10] = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND};
	localparam ALU_FUNC MUL_FN [4] = '{ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};
	localparam logic [2:0] BR_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [2:0] LD_F3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

	typedef struct packed {
		logic [ROB_TAG_W-1:0] tag;
		logic [4:0]           dest;
		logic                 done;
		logic [XLEN-1:0]      value;
	} rob_entry_t;

	logic         clock;
	logic         rst_n;
	logic         kill;
	IF_ID_PACKET  if_packet;
	CDB_PACKET    cdb;
	ID_EX_PACKET  id_packet;
	logic         stall;
	COMMIT_PACKET commit;

	integer               seed;
	int                   checks, errors, tests;
	int unsigned          cycles = 0;
	logic [XLEN-1:0]      arch [32];      // committed register state
	logic                 ren_busy [32];
	logic [ROB_TAG_W-1:0] ren_tag [32];
	rob_entry_t           model_q [$];    // in flight, oldest first
	logic [ROB_TAG_W-1:0] tail_tag;
	logic                 hold;
	IF_ID_PACKET          cur_pkt;
	ID_EX_PACKET          cur_exp, exp_pkt;
	COMMIT_PACKET         exp_commit;
	logic                 exp_stall;

	issue_top #(.ROB_DEPTH(ROB_DEPTH)) dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.if_packet (if_packet),
		.cdb       (cdb),
		.kill      (kill),
		.id_packet (id_packet),
		.stall     (stall),
		.commit    (commit)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic int unsigned urand(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check_packet(input string name, input ID_EX_PACKET exp, input ID_EX_PACKET act);
		ID_EX_PACKET a;
		a = act;
		if (exp.rs1_pending)
			a.rs1_value = exp.rs1_value;  // a pending source carries no value
		if (exp.rs2_pending)
			a.rs2_value = exp.rs2_value;
		checks++;
		if (a !== exp) begin
			errors++;
			$display("FAIL %s (test %0d): expected %h, actual %h", name, tests, exp, a);
		end
	endtask

	task automatic check_commit(input string name, input COMMIT_PACKET exp, input COMMIT_PACKET act);
		COMMIT_PACKET a;
		a = act;
		if (!exp.valid) begin
			a.reg_wr_idx = exp.reg_wr_idx;  // stale head fields when idle
			a.data       = exp.data;
		end
		checks++;
		if (a !== exp) begin
			errors++;
			$display("FAIL %s (test %0d): expected %h, actual %h", name, tests, exp, a);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s (test %0d): expected %b, actual %b", name, tests, exp, act);
		end
	endtask

	// random packet plus its expected decode; all-zero fields are the noop
	task automatic gen_inst(output IF_ID_PACKET p, output ID_EX_PACKET e);
		int unsigned sel;
		int unsigned k;
		INST w;
		sel = urand(40);
		w.raw = $random(seed);
		w.r.rd  = 5'(urand(8));  // few registers, many dependencies
		w.r.rs1 = 5'(urand(8));
		w.r.rs2 = 5'(urand(8));
		e = '0;
		p.valid = 1'b1;
		p.PC = $random(seed);
		p.PC[1:0] = 2'b00;
		p.NPC = p.PC + 32'd4;
		if (sel < 4) begin
			w.r.opcode = 7'b0001011;  // custom-0, unknown to the decoder
			e.illegal = 1'b1;
		end else if (sel == 4) begin
			w.raw = WFI;
			e.halt = 1'b1;
		end else if (sel < 7) begin
			p.valid = 1'b0;
		end else begin
			case (sel % 11)
				0, 1: begin
					w.r.opcode = (sel % 11 == 0) ? RV32_LUI[6:0] : RV32_AUIPC[6:0];
					e.opa_select = (sel % 11 == 0) ? OPA_IS_ZERO : OPA_IS_PC;
					e.opb_select = OPB_IS_U_IMM;
					e.dest_reg_idx = w.r.rd;
				end
				2: begin
					w.r.opcode = RV32_JAL[6:0];
					e.opa_select = OPA_IS_PC;
					e.opb_select = OPB_IS_J_IMM;
					e.uncond_branch = 1'b1;
					e.dest_reg_idx = w.r.rd;
				end
				3: begin
					w.r.opcode = RV32_JALR[6:0];
					w.r.funct3 = 3'd0;
					e.opb_select = OPB_IS_I_IMM;
					e.uncond_branch = 1'b1;
					e.dest_reg_idx = w.r.rd;
				end
				4: begin
					w.r.opcode = RV32_BEQ[6:0];
					w.r.funct3 = BR_F3[urand(6)];
					e.opa_select = OPA_IS_PC;
					e.opb_select = OPB_IS_B_IMM;
					e.cond_branch = 1'b1;
				end
				5: begin
					w.r.opcode = RV32_LW[6:0];
					w.r.funct3 = LD_F3[urand(5)];
					e.opb_select = OPB_IS_I_IMM;
					e.rd_mem = 1'b1;
					e.dest_reg_idx = w.r.rd;
				end
				6: begin
					w.r.opcode = RV32_SW[6:0];
					w.r.funct3 = 3'(urand(3));
					e.opb_select = OPB_IS_S_IMM;
					e.wr_mem = 1'b1;
				end
				7: begin
					k = urand(9);
					w.r.opcode = RV32_ADDI[6:0];
					w.r.funct3 = IMM_F3[k];
					if (k >= 6)
						w.r.funct7 = IMM_F7[k];  // shift amount forms
					e.opb_select = OPB_IS_I_IMM;
					e.alu_func = IMM_FN[k];
					e.dest_reg_idx = w.r.rd;
				end
				8: begin
					k = urand(10);
					w.r.opcode = RV32_ADD[6:0];
					w.r.funct3 = REG_F3[k];
					w.r.funct7 = REG_F7[k];
					e.alu_func = REG_FN[k];
					e.dest_reg_idx = w.r.rd;
				end
				9: begin
					k = urand(4);
					w.r.opcode = RV32_MUL[6:0];
					w.r.funct3 = 3'(k);
					w.r.funct7 = 7'h01;
					e.alu_func = MUL_FN[k];
					e.dest_reg_idx = w.r.rd;
				end
				default: begin
					w.r.opcode = RV32_CSRRW[6:0];
					w.r.funct3 = 3'(1 + urand(3));
					e.csr_op = 1'b1;
				end
			endcase
		end
		p.inst = w;
		e.inst = w;
		e.PC   = p.PC;
		e.NPC  = p.NPC;
	endtask

	// latest producer decides: none, completed, or still pending
	task automatic expect_source(input logic [4:0] r, output logic [XLEN-1:0] val,
			output logic [ROB_TAG_W-1:0] tag, output logic pend);
		val  = arch[r];
		tag  = '0;
		pend = 1'b0;
		if (ren_busy[r]) begin
			tag  = ren_tag[r];
			pend = 1'b1;
			foreach (model_q[i]) begin
				if (model_q[i].tag == ren_tag[r] && model_q[i].done) begin
					pend = 1'b0;
					val  = model_q[i].value;
				end
			end
		end
	endtask

	task automatic drive_inputs();
		int open [$];
		int pick;
		if (!hold) begin
			gen_inst(cur_pkt, cur_exp);
			tests++;
		end
		if_packet = cur_pkt;
		kill = (urand(60) == 0);
		cdb = '0;
		if (!kill && urand(2) == 0) begin
			foreach (model_q[i])
				if (!model_q[i].done)
					open.push_back(i);
			if (open.size() > 0) begin
				pick = open[urand(open.size())];
				cdb.valid   = 1'b1;
				cdb.rob_tag = model_q[pick].tag;
				cdb.value   = $random(seed);
			end
		end
	endtask

	task automatic check_outputs();
		exp_stall = (model_q.size() == ROB_DEPTH);
		exp_commit = '0;
		if (model_q.size() > 0 && model_q[0].done) begin
			exp_commit.valid      = 1'b1;
			exp_commit.reg_wr_en  = (model_q[0].dest != ZERO_REG);
			exp_commit.reg_wr_idx = model_q[0].dest;
			exp_commit.data       = model_q[0].value;
		end
		exp_pkt = cur_exp;
		expect_source(cur_pkt.inst.r.rs1, exp_pkt.rs1_value, exp_pkt.rs1_tag, exp_pkt.rs1_pending);
		expect_source(cur_pkt.inst.r.rs2, exp_pkt.rs2_value, exp_pkt.rs2_tag, exp_pkt.rs2_pending);
		exp_pkt.dest_tag = tail_tag;
		exp_pkt.valid = cur_pkt.valid && !cur_exp.illegal && !cur_exp.halt && !exp_stall && !kill;
		check_bit("stall", exp_stall, stall);
		check_commit("commit", exp_commit, commit);
		check_packet("issue", exp_pkt, id_packet);
	endtask

	// what the coming rising edge does to the model
	task automatic update_model();
		logic [4:0] d;
		if (cdb.valid) begin
			foreach (model_q[i]) begin
				if (model_q[i].tag == cdb.rob_tag) begin
					model_q[i].done  = 1'b1;
					model_q[i].value = cdb.value;
				end
			end
		end
		if (exp_commit.valid) begin
			d = model_q[0].dest;
			if (exp_commit.reg_wr_en)
				arch[d] = model_q[0].value;
			if (ren_busy[d] && ren_tag[d] == model_q[0].tag)
				ren_busy[d] = 1'b0;
			void'(model_q.pop_front());
		end
		if (exp_pkt.valid) begin
			d = exp_pkt.dest_reg_idx;
			model_q.push_back('{tag: tail_tag, dest: d, done: 1'b0, value: '0});
			if (d != ZERO_REG) begin
				ren_busy[d] = 1'b1;  // rename wins over a same-edge clear
				ren_tag[d]  = tail_tag;
			end
			tail_tag = (int'(tail_tag) == ROB_DEPTH - 1) ? '0 : tail_tag + 1'b1;
		end
		if (kill) begin
			model_q.delete();
			ren_busy = '{default: 1'b0};
			tail_tag = '0;
		end
		hold = exp_stall;  // fetch keeps offering the same packet
	endtask

	initial begin
		seed      = 32'h292a;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		hold      = 1'b0;
		tail_tag  = '0;
		arch      = '{default: '0};
		ren_busy  = '{default: 1'b0};
		ren_tag   = '{default: '0};
		rst_n     = 1'b0;
		kill      = 1'b0;
		if_packet = '0;
		cdb       = '0;
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
		while (tests < NUM_TESTS) begin
			drive_inputs();
			#10;
			check_outputs();
			update_model();
			@(negedge clock);
		end
		$display("tests %0d, checks %0d, errors %0d, cycles %0d", tests, checks, errors, cycles);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: files.f
hdl/issue_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/map_table.sv
hdl/rob.sv
hdl/is_stage.sv
hdl/issue_top.sv
bench/issue_asserts.sv
bench/issue_tb.sv

// File: hdl/decoder.sv
`timescale 1ns/100ps

module decoder import issue_pkg::*; (
	input IF_ID_PACKET    if_packet,
	output ALU_OPA_SELECT opa_select,
	output ALU_OPB_SELECT opb_select,
	output DEST_REG_SEL   dest_reg,
	output ALU_FUNC       alu_func,
	output logic          rd_mem, wr_mem, cond_branch, uncond_branch,
	output logic          csr_op,
	output logic          halt,
	output logic          illegal,
	output logic          valid_inst  // low on halt and illegal
);

	INST inst;

	// shared funct3 map of the base integer ops, alt picks sub/sra
	function automatic ALU_FUNC base_func(input logic [2:0] funct3, input logic alt);
		case (funct3)
			3'b000:  base_func = alt ? ALU_SUB : ALU_ADD;
			3'b001:  base_func = ALU_SLL;
			3'b010:  base_func = ALU_SLT;
			3'b011:  base_func = ALU_SLTU;
			3'b100:  base_func = ALU_XOR;
			3'b101:  base_func = alt ? ALU_SRA : ALU_SRL;
			3'b110:  base_func = ALU_OR;
			default: base_func = ALU_AND;
		endcase
	endfunction

	assign inst       = if_packet.inst;
	assign valid_inst = if_packet.valid & ~illegal & ~halt;

	always_comb begin
		// noop unless a group below says otherwise
		opa_select    = OPA_IS_RS1;
		opb_select    = OPB_IS_RS2;
		alu_func      = ALU_ADD;
		dest_reg      = DEST_NONE;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (if_packet.valid) begin
			casez (inst.raw)
				RV32_LUI: begin
					dest_reg   = DEST_RD;
					opa_select = OPA_IS_ZERO;
					opb_select = OPB_IS_U_IMM;
				end
				RV32_AUIPC: begin
					dest_reg   = DEST_RD;
					opa_select = OPA_IS_PC;
					opb_select = OPB_IS_U_IMM;
				end
				RV32_JAL: begin
					dest_reg      = DEST_RD;
					opa_select    = OPA_IS_PC;
					opb_select    = OPB_IS_J_IMM;
					uncond_branch = 1'b1;
				end
				RV32_JALR: begin
					dest_reg      = DEST_RD;
					opb_select    = OPB_IS_I_IMM;
					uncond_branch = 1'b1;
				end
				RV32_BEQ, RV32_BNE, RV32_BLT, RV32_BGE, RV32_BLTU, RV32_BGEU: begin
					opa_select  = OPA_IS_PC;
					opb_select  = OPB_IS_B_IMM;
					cond_branch = 1'b1;
				end
				RV32_LB, RV32_LH, RV32_LW, RV32_LBU, RV32_LHU: begin
					dest_reg   = DEST_RD;
					opb_select = OPB_IS_I_IMM;
					rd_mem     = 1'b1;
				end
				RV32_SB, RV32_SH, RV32_SW: begin
					opb_select = OPB_IS_S_IMM;
					wr_mem     = 1'b1;
				end
				RV32_ADDI, RV32_SLTI, RV32_SLTIU, RV32_XORI, RV32_ORI, RV32_ANDI,
				RV32_SLLI, RV32_SRLI, RV32_SRAI: begin
					dest_reg   = DEST_RD;
					opb_select = OPB_IS_I_IMM;
					// imm bit 10 only means arithmetic shift under funct3 101
					alu_func   = base_func(inst.i.funct3,
						inst.r.funct7[5] & (inst.i.funct3 == 3'b101));
				end
				RV32_ADD, RV32_SUB, RV32_SLL, RV32_SLT, RV32_SLTU,
				RV32_XOR, RV32_SRL, RV32_SRA, RV32_OR, RV32_AND: begin
					dest_reg = DEST_RD;
					alu_func = base_func(inst.r.funct3, inst.r.funct7[5]);
				end
				RV32_MUL, RV32_MULH, RV32_MULHSU, RV32_MULHU: begin
					dest_reg = DEST_RD;
					case (inst.r.funct3[1:0])
						2'b00:   alu_func = ALU_MUL;
						2'b01:   alu_func = ALU_MULH;
						2'b10:   alu_func = ALU_MULHSU;
						default: alu_func = ALU_MULHU;
					endcase
				end
				RV32_CSRRW, RV32_CSRRS, RV32_CSRRC: csr_op = 1'b1;
				WFI: halt = 1'b1;
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

// File: hdl/is_stage.sv
`timescale 1ns/100ps

module is_stage import issue_pkg::*; (
	input logic                 clock,
	input logic                 rst_n,
	input IF_ID_PACKET          if_packet,
	input MAPTABLE_PACKET       maptable_rs1,
	input MAPTABLE_PACKET       maptable_rs2,
	input logic [XLEN-1:0]      rob_rs1_value,
	input logic [XLEN-1:0]      rob_rs2_value,
	input logic [ROB_TAG_W-1:0] alloc_tag,
	input logic                 stall,
	input logic                 kill,
	input COMMIT_PACKET         commit,      // register-file write port
	output ID_EX_PACKET         id_packet,
	output logic                issue_fire
);

	logic [XLEN-1:0] regf_rs1_value, regf_rs2_value;
	DEST_REG_SEL     dest_reg_select;
	logic            valid_inst;

	regfile regf_0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.rda_idx (if_packet.inst.r.rs1),
		.rdb_idx (if_packet.inst.r.rs2),
		.rda_out (regf_rs1_value),
		.rdb_out (regf_rs2_value),
		.wr_en   (commit.reg_wr_en),
		.wr_idx  (commit.reg_wr_idx),
		.wr_data (commit.data)
	);

	decoder decoder_0 (
		.if_packet     (if_packet),
		.opa_select    (id_packet.opa_select),
		.opb_select    (id_packet.opb_select),
		.dest_reg      (dest_reg_select),
		.alu_func      (id_packet.alu_func),
		.rd_mem        (id_packet.rd_mem),
		.wr_mem        (id_packet.wr_mem),
		.cond_branch   (id_packet.cond_branch),
		.uncond_branch (id_packet.uncond_branch),
		.csr_op        (id_packet.csr_op),
		.halt          (id_packet.halt),
		.illegal       (id_packet.illegal),
		.valid_inst    (valid_inst)
	);

	assign issue_fire = valid_inst & ~stall & ~kill;

	assign id_packet.inst     = if_packet.inst;
	assign id_packet.PC       = if_packet.PC;
	assign id_packet.NPC      = if_packet.NPC;
	assign id_packet.dest_tag = alloc_tag;
	assign id_packet.valid    = issue_fire;  // held or killed packets don't issue

	assign id_packet.dest_reg_idx = (dest_reg_select == DEST_RD) ?
		if_packet.inst.r.rd : ZERO_REG;

	// completed producer reads from rob, no producer from the register file
	assign id_packet.rs1_value = (maptable_rs1.busy && maptable_rs1.rob_tag_ready) ?
		rob_rs1_value : regf_rs1_value;
	assign id_packet.rs2_value = (maptable_rs2.busy && maptable_rs2.rob_tag_ready) ?
		rob_rs2_value : regf_rs2_value;

	assign id_packet.rs1_pending = maptable_rs1.busy & ~maptable_rs1.rob_tag_ready;
	assign id_packet.rs2_pending = maptable_rs2.busy & ~maptable_rs2.rob_tag_ready;
	assign id_packet.rs1_tag     = maptable_rs1.rob_tag;
	assign id_packet.rs2_tag     = maptable_rs2.rob_tag;

endmodule

// File: hdl/issue_pkg.sv
package issue_pkg;

	localparam int XLEN = 32;
	localparam int ROB_TAG_W = 3;   // width at the default depth of 8
	localparam logic [4:0] ZERO_REG = 5'd0;

	// match patterns, laid out as funct7_rs2_rs1_funct3_rd_opcode
	localparam logic [31:0] RV32_LUI    = 32'b???????_?????_?????_???_?????_0110111;
	localparam logic [31:0] RV32_AUIPC  = 32'b???????_?????_?????_???_?????_0010111;
	localparam logic [31:0] RV32_JAL    = 32'b???????_?????_?????_???_?????_1101111;
	localparam logic [31:0] RV32_JALR   = 32'b???????_?????_?????_000_?????_1100111;
	localparam logic [31:0] RV32_BEQ    = 32'b???????_?????_?????_000_?????_1100011;
	localparam logic [31:0] RV32_BNE    = 32'b???????_?????_?????_001_?????_1100011;
	localparam logic [31:0] RV32_BLT    = 32'b???????_?????_?????_100_?????_1100011;
	localparam logic [31:0] RV32_BGE    = 32'b???????_?????_?????_101_?????_1100011;
	localparam logic [31:0] RV32_BLTU   = 32'b???????_?????_?????_110_?????_1100011;
	localparam logic [31:0] RV32_BGEU   = 32'b???????_?????_?????_111_?????_1100011;
	localparam logic [31:0] RV32_LB     = 32'b???????_?????_?????_000_?????_0000011;
	localparam logic [31:0] RV32_LH     = 32'b???????_?????_?????_001_?????_0000011;
	localparam logic [31:0] RV32_LW     = 32'b???????_?????_?????_010_?????_0000011;
	localparam logic [31:0] RV32_LBU    = 32'b???????_?????_?????_100_?????_0000011;
	localparam logic [31:0] RV32_LHU    = 32'b???????_?????_?????_101_?????_0000011;
	localparam logic [31:0] RV32_SB     = 32'b???????_?????_?????_000_?????_0100011;
	localparam logic [31:0] RV32_SH     = 32'b???????_?????_?????_001_?????_0100011;
	localparam logic [31:0] RV32_SW     = 32'b???????_?????_?????_010_?????_0100011;
	localparam logic [31:0] RV32_ADDI   = 32'b???????_?????_?????_000_?????_0010011;
	localparam logic [31:0] RV32_SLTI   = 32'b???????_?????_?????_010_?????_0010011;
	localparam logic [31:0] RV32_SLTIU  = 32'b???????_?????_?????_011_?????_0010011;
	localparam logic [31:0] RV32_XORI   = 32'b???????_?????_?????_100_?????_0010011;
	localparam logic [31:0] RV32_ORI    = 32'b???????_?????_?????_110_?????_0010011;
	localparam logic [31:0] RV32_ANDI   = 32'b???????_?????_?????_111_?????_0010011;
	localparam logic [31:0] RV32_SLLI   = 32'b0000000_?????_?????_001_?????_0010011;
	localparam logic [31:0] RV32_SRLI   = 32'b0000000_?????_?????_101_?????_0010011;
	localparam logic [31:0] RV32_SRAI   = 32'b0100000_?????_?????_101_?????_0010011;
	localparam logic [31:0] RV32_ADD    = 32'b0000000_?????_?????_000_?????_0110011;
	localparam logic [31:0] RV32_SUB    = 32'b0100000_?????_?????_000_?????_0110011;
	localparam logic [31:0] RV32_SLL    = 32'b0000000_?????_?????_001_?????_0110011;
	localparam logic [31:0] RV32_SLT    = 32'b0000000_?????_?????_010_?????_0110011;
	localparam logic [31:0] RV32_SLTU   = 32'b0000000_?????_?????_011_?????_0110011;
	localparam logic [31:0] RV32_XOR    = 32'b0000000_?????_?????_100_?????_0110011;
	localparam logic [31:0] RV32_SRL    = 32'b0000000_?????_?????_101_?????_0110011;
	localparam logic [31:0] RV32_SRA    = 32'b0100000_?????_?????_101_?????_0110011;
	localparam logic [31:0] RV32_OR     = 32'b0000000_?????_?????_110_?????_0110011;
	localparam logic [31:0] RV32_AND    = 32'b0000000_?????_?????_111_?????_0110011;
	localparam logic [31:0] RV32_MUL    = 32'b0000001_?????_?????_000_?????_0110011;
	localparam logic [31:0] RV32_MULH   = 32'b0000001_?????_?????_001_?????_0110011;
	localparam logic [31:0] RV32_MULHSU = 32'b0000001_?????_?????_010_?????_0110011;
	localparam logic [31:0] RV32_MULHU  = 32'b0000001_?????_?????_011_?????_0110011;
	localparam logic [31:0] RV32_CSRRW  = 32'b???????_?????_?????_001_?????_1110011;
	localparam logic [31:0] RV32_CSRRS  = 32'b???????_?????_?????_010_?????_1110011;
	localparam logic [31:0] RV32_CSRRC  = 32'b???????_?????_?????_011_?????_1110011;
	localparam logic [31:0] WFI         = 32'b0001000_00101_00000_000_00000_1110011;

	typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO} ALU_OPA_SELECT;

	typedef enum logic [2:0] {
		OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
		OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
	} ALU_OPB_SELECT;

	typedef enum logic {DEST_RD, DEST_NONE} DEST_REG_SEL;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
	} ALU_FUNC;

	// one word, seen in each encoding format
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] off;    // imm[11:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] set;    // imm[4:0]
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       of;     // imm[12]
			logic [5:0] s;      // imm[10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] et;     // imm[4:1]
			logic       f;      // imm[11]
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       of;     // imm[20]
			logic [9:0] et;     // imm[10:1]
			logic       s;      // imm[11]
			logic [7:0] f;      // imm[19:12]
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} INST;

	typedef struct packed {
		INST             inst;
		logic [XLEN-1:0] PC;
		logic [XLEN-1:0] NPC;
		logic            valid;
	} IF_ID_PACKET;

	typedef struct packed {
		logic                 busy;           // producer still in flight
		logic [ROB_TAG_W-1:0] rob_tag;
		logic                 rob_tag_ready;  // producer has completed
	} MAPTABLE_PACKET;

	typedef struct packed {
		INST                  inst;
		logic [XLEN-1:0]      PC;
		logic [XLEN-1:0]      NPC;
		logic [XLEN-1:0]      rs1_value;
		logic [XLEN-1:0]      rs2_value;
		logic [ROB_TAG_W-1:0] rs1_tag;
		logic [ROB_TAG_W-1:0] rs2_tag;
		logic                 rs1_pending, rs2_pending;
		ALU_OPA_SELECT        opa_select;
		ALU_OPB_SELECT        opb_select;
		ALU_FUNC              alu_func;
		logic [4:0]           dest_reg_idx;
		logic [ROB_TAG_W-1:0] dest_tag;
		logic                 rd_mem, wr_mem, cond_branch, uncond_branch;
		logic                 csr_op, halt, illegal, valid;
	} ID_EX_PACKET;

	typedef struct packed {
		logic                 valid;
		logic [ROB_TAG_W-1:0] rob_tag;
		logic [XLEN-1:0]      value;
	} CDB_PACKET;

	typedef struct packed {
		logic            valid;
		logic            reg_wr_en;
		logic [4:0]      reg_wr_idx;
		logic [XLEN-1:0] data;
	} COMMIT_PACKET;

endpackage

// File: hdl/issue_top.sv
`timescale 1ns/100ps

module issue_top import issue_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input logic          clock,
	input logic          rst_n,
	input IF_ID_PACKET   if_packet,
	input CDB_PACKET     cdb,
	input logic          kill,
	output ID_EX_PACKET  id_packet,
	output logic         stall,   // rob full, fetch holds its packet
	output COMMIT_PACKET commit
);

	MAPTABLE_PACKET       maptable_rs1, maptable_rs2;
	logic [XLEN-1:0]      rob_rs1_value, rob_rs2_value;
	logic [ROB_TAG_W-1:0] alloc_tag;
	logic [ROB_TAG_W-1:0] commit_tag;
	logic                 issue_fire;

	is_stage is_stage_0 (
		.clock         (clock),
		.rst_n         (rst_n),
		.if_packet     (if_packet),
		.maptable_rs1  (maptable_rs1),
		.maptable_rs2  (maptable_rs2),
		.rob_rs1_value (rob_rs1_value),
		.rob_rs2_value (rob_rs2_value),
		.alloc_tag     (alloc_tag),
		.stall         (stall),
		.kill          (kill),
		.commit        (commit),
		.id_packet     (id_packet),
		.issue_fire    (issue_fire)
	);

	map_table map_table_0 (
		.clock        (clock),
		.rst_n        (rst_n),
		.rs1_idx      (if_packet.inst.r.rs1),
		.rs2_idx      (if_packet.inst.r.rs2),
		.issue_fire   (issue_fire),
		.dest_idx     (id_packet.dest_reg_idx),
		.alloc_tag    (alloc_tag),
		.cdb          (cdb),
		.commit_tag   (commit_tag),
		.commit_valid (commit.valid),
		.kill         (kill),
		.maptable_rs1 (maptable_rs1),
		.maptable_rs2 (maptable_rs2)
	);

	rob #(.ROB_DEPTH(ROB_DEPTH)) rob_0 (
		.clock      (clock),
		.rst_n      (rst_n),
		.issue_fire (issue_fire),
		.dest_idx   (id_packet.dest_reg_idx),
		.cdb        (cdb),
		.kill       (kill),
		.rd_tag1    (maptable_rs1.rob_tag),
		.rd_tag2    (maptable_rs2.rob_tag),
		.rd_value1  (rob_rs1_value),
		.rd_value2  (rob_rs2_value),
		.alloc_tag  (alloc_tag),
		.full       (stall),
		.commit     (commit),
		.commit_tag (commit_tag)
	);

endmodule

// File: hdl/map_table.sv
`timescale 1ns/100ps

module map_table import issue_pkg::*; (
	input logic                 clock,
	input logic                 rst_n,
	input logic [4:0]           rs1_idx,
	input logic [4:0]           rs2_idx,
	input logic                 issue_fire,
	input logic [4:0]           dest_idx,
	input logic [ROB_TAG_W-1:0] alloc_tag,
	input CDB_PACKET            cdb,
	input logic [ROB_TAG_W-1:0] commit_tag,
	input logic                 commit_valid,
	input logic                 kill,
	output MAPTABLE_PACKET      maptable_rs1,
	output MAPTABLE_PACKET      maptable_rs2
);

	MAPTABLE_PACKET entry [32];

	assign maptable_rs1 = entry[rs1_idx];
	assign maptable_rs2 = entry[rs2_idx];

	always_ff @(posedge clock) begin
		if (!rst_n || kill) begin
			entry <= '{default: '0};
		end else begin
			for (int r = 1; r < 32; r++) begin
				// retire clears only if nothing renamed r since
				if (commit_valid && entry[r].busy && entry[r].rob_tag == commit_tag)
					entry[r] <= '0;
				else if (cdb.valid && entry[r].busy && entry[r].rob_tag == cdb.rob_tag)
					entry[r].rob_tag_ready <= 1'b1;
			end
			// last assignment, so a same-edge rename beats the clear
			if (issue_fire && dest_idx != ZERO_REG) begin
				entry[dest_idx] <= '{busy: 1'b1, rob_tag: alloc_tag, rob_tag_ready: 1'b0};
			end
		end
	end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/100ps

module regfile import issue_pkg::*; (
	input logic              clock,
	input logic              rst_n,
	input logic [4:0]        rda_idx,
	input logic [4:0]        rdb_idx,
	output logic [XLEN-1:0]  rda_out,
	output logic [XLEN-1:0]  rdb_out,
	input logic              wr_en,
	input logic [4:0]        wr_idx,
	input logic [XLEN-1:0]   wr_data
);

	logic [XLEN-1:0] regs [32];  // entry 0 is never written

	// write-through so a read in the commit cycle sees the new value
	assign rda_out = (rda_idx == ZERO_REG) ? '0 :
		(wr_en && wr_idx == rda_idx) ? wr_data : regs[rda_idx];
	assign rdb_out = (rdb_idx == ZERO_REG) ? '0 :
		(wr_en && wr_idx == rdb_idx) ? wr_data : regs[rdb_idx];

	always_ff @(posedge clock) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (wr_en && wr_idx != ZERO_REG)
			regs[wr_idx] <= wr_data;
	end

endmodule

// File: hdl/rob.sv
`timescale 1ns/100ps

module rob import issue_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input logic                  clock,
	input logic                  rst_n,
	input logic                  issue_fire,
	input logic [4:0]            dest_idx,
	input CDB_PACKET             cdb,
	input logic                  kill,
	input logic [ROB_TAG_W-1:0]  rd_tag1,
	input logic [ROB_TAG_W-1:0]  rd_tag2,
	output logic [XLEN-1:0]      rd_value1,
	output logic [XLEN-1:0]      rd_value2,
	output logic [ROB_TAG_W-1:0] alloc_tag,
	output logic                 full,
	output COMMIT_PACKET         commit,
	output logic [ROB_TAG_W-1:0] commit_tag
);

	localparam int IDX_W = $clog2(ROB_DEPTH);

	typedef struct packed {
		logic       done;
		logic [4:0] dest;
	} rob_ctrl_t;

	rob_ctrl_t       ctrl  [ROB_DEPTH];
	logic [XLEN-1:0] value [ROB_DEPTH];
	logic [IDX_W-1:0] head, tail;
	logic [IDX_W:0]   count;
	logic [IDX_W-1:0] cdb_idx;

	// wrap explicitly, depth need not be a power of two
	function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] p);
		return (p == IDX_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign cdb_idx    = IDX_W'(cdb.rob_tag);
	assign rd_value1  = value[IDX_W'(rd_tag1)];
	assign rd_value2  = value[IDX_W'(rd_tag2)];
	assign alloc_tag  = ROB_TAG_W'(tail);
	assign commit_tag = ROB_TAG_W'(head);
	assign full       = (count == (IDX_W+1)'(ROB_DEPTH));

	always_comb begin
		commit.valid      = (count != '0) && ctrl[head].done;
		commit.reg_wr_en  = commit.valid && (ctrl[head].dest != ZERO_REG);
		commit.reg_wr_idx = ctrl[head].dest;
		commit.data       = value[head];
	end

	always_ff @(posedge clock) begin
		if (!rst_n || kill) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (issue_fire)
				tail <= next_ptr(tail);
			if (commit.valid)
				head <= next_ptr(head);
			count <= count + {{IDX_W{1'b0}}, issue_fire} - {{IDX_W{1'b0}}, commit.valid};
		end
	end

	// entry contents, only meaningful between head and tail
	always_ff @(posedge clock) begin
		if (issue_fire)
			ctrl[tail] <= '{done: 1'b0, dest: dest_idx};
		if (cdb.valid) begin
			ctrl[cdb_idx].done <= 1'b1;
			value[cdb_idx]     <= cdb.value;
		end
	end

endmodule
